// File: hw/mdio_pkg.sv
package mdio_pkg;

    //////////////////////////////////////////////////////////////////////
    // clause-22 frame layout
    //////////////////////////////////////////////////////////////////////

    // preamble of all ones ahead of every frame
    localparam int PREAMBLE_LEN = 32;

    // start, opcode, phy address and register address
    localparam int CMD_LEN = 14;

    // turnaround, the phy takes the line here
    localparam int TA_LEN = 2;

    // read data, msb first
    localparam int DATA_LEN = 16;

    localparam logic [1:0] START_BITS = 2'b01;
    localparam logic [1:0] OP_READ    = 2'b10;

    // address of the one phy on the bus
    localparam logic [4:0] PHY_ADDR = 5'd0;

    //////////////////////////////////////////////////////////////////////
    // sweep and dump
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_REGS = 32;

    // mdc cycles to let the phy settle after reset
    localparam int POST_RESET_WAIT = 100;

    localparam logic [3:0] DUMP_TAG = 4'hA;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // one dump word: A, 000, addr, 0000, data
    typedef struct packed {
        logic [3:0] tag;
        logic [2:0] pad_hi;
        reg_addr_t  addr;
        logic [3:0] pad_lo;
        reg_data_t  data;
    } dump_word_t;

endpackage

// File: hw/mdio_frame_engine.sv
`timescale 1ns/1ps

module mdio_frame_engine (
    input  logic                enet_mdc_clk,
    input  logic                CPU_RESETn,
    input  logic                rd_req,
    input  mdio_pkg::reg_addr_t rd_addr,
    output logic                rd_ack,
    output mdio_pkg::reg_data_t rd_data,
    output logic                mdio_out,
    output logic                mdio_oe,
    input  logic                mdio_in
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_COMMAND,
        ST_TURNAROUND,
        ST_READ,
        ST_ACK
    } state_t;

    state_t state;

    // one counter for every phase of the frame
    logic [4:0] bit_cnt;
    logic [4:0] phase_last;
    logic       last_bit;

    // start, opcode, phy address, register address
    logic [mdio_pkg::CMD_LEN-1:0] cmd_sr;

    //////////////////////////////////////////////////////////////////////
    // phase length
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            ST_PREAMBLE:   phase_last = 5'(mdio_pkg::PREAMBLE_LEN - 1);
            ST_COMMAND:    phase_last = 5'(mdio_pkg::CMD_LEN - 1);
            ST_TURNAROUND: phase_last = 5'(mdio_pkg::TA_LEN - 1);
            ST_READ:       phase_last = 5'(mdio_pkg::DATA_LEN - 1);
            default:       phase_last = '0;
        endcase
    end

    // idle and ack sit at zero, so the counter is clear on entry to a phase
    assign last_bit = (bit_cnt == phase_last);

    //////////////////////////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge enet_mdc_clk) begin
        if (!CPU_RESETn) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
        end else begin
            bit_cnt <= last_bit ? 5'd0 : bit_cnt + 5'd1;
            case (state)
                ST_IDLE: begin
                    if (rd_req) begin
                        state <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    if (last_bit) begin
                        state <= ST_COMMAND;
                    end
                end
                ST_COMMAND: begin
                    if (last_bit) begin
                        state <= ST_TURNAROUND;
                    end
                end
                ST_TURNAROUND: begin
                    if (last_bit) begin
                        state <= ST_READ;
                    end
                end
                ST_READ: begin
                    // the edge taking bit 0 also raises rd_ack
                    if (last_bit) begin
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (!rd_req) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // command shift out, data shift in
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge enet_mdc_clk) begin
        if (state == ST_IDLE && rd_req) begin
            cmd_sr <= {mdio_pkg::START_BITS, mdio_pkg::OP_READ, mdio_pkg::PHY_ADDR, rd_addr};
        end else if (state == ST_COMMAND) begin
            cmd_sr <= {cmd_sr[mdio_pkg::CMD_LEN-2:0], 1'b0};
        end
        // data arrives msb first
        if (state == ST_READ) begin
            rd_data <= {rd_data[mdio_pkg::DATA_LEN-2:0], mdio_in};
        end
    end

    // line idles high, so the preamble needs no shift register
    assign mdio_out = (state == ST_COMMAND) ? cmd_sr[mdio_pkg::CMD_LEN-1] : 1'b1;
    assign mdio_oe  = (state == ST_PREAMBLE) || (state == ST_COMMAND);
    assign rd_ack   = (state == ST_ACK);

endmodule

// File: hw/phy_reg_sweep.sv
`timescale 1ns/1ps

module phy_reg_sweep (
    input  logic                enet_mdc_clk,
    input  logic                CPU_RESETn,
    output logic                rd_req,
    output mdio_pkg::reg_addr_t rd_addr,
    input  logic                rd_ack,
    input  mdio_pkg::reg_data_t rd_data,
    output logic                wr_en,
    output mdio_pkg::reg_addr_t wr_addr,
    output mdio_pkg::reg_data_t wr_data,
    output logic                sweep_done
);

    typedef enum logic [1:0] {
        SW_WAIT,
        SW_REQ,
        SW_RELEASE,
        SW_DONE
    } sweep_state_t;

    sweep_state_t state;

    // settling counter after reset release
    logic [$clog2(mdio_pkg::POST_RESET_WAIT)-1:0] wait_cnt;

    always_ff @(posedge enet_mdc_clk) begin
        if (!CPU_RESETn) begin
            state      <= SW_WAIT;
            wait_cnt   <= '0;
            rd_req     <= 1'b0;
            rd_addr    <= '0;
            wr_en      <= 1'b0;
            sweep_done <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                SW_WAIT: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (int'(wait_cnt) == mdio_pkg::POST_RESET_WAIT - 1) begin
                        rd_req <= 1'b1;
                        state  <= SW_REQ;
                    end
                end
                SW_REQ: begin
                    // store the value once, then release the request
                    if (rd_ack) begin
                        wr_en  <= 1'b1;
                        rd_req <= 1'b0;
                        state  <= SW_RELEASE;
                    end
                end
                SW_RELEASE: begin
                    if (!rd_ack) begin
                        if (rd_addr == 5'(mdio_pkg::NUM_REGS - 1)) begin
                            sweep_done <= 1'b1;
                            state      <= SW_DONE;
                        end else begin
                            rd_addr <= rd_addr + 5'd1;
                            rd_req  <= 1'b1;
                            state   <= SW_REQ;
                        end
                    end
                end
                default: begin
                    // sweep_done holds until the next reset
                end
            endcase
        end
    end

    // engine keeps rd_data steady through the ack phase
    assign wr_addr = rd_addr;
    assign wr_data = rd_data;

endmodule

// File: hw/phy_reg_file.sv
`timescale 1ns/1ps

module phy_reg_file (
    input  logic                enet_mdc_clk,
    input  logic                wr_en,
    input  mdio_pkg::reg_addr_t wr_addr,
    input  mdio_pkg::reg_data_t wr_data,
    input  mdio_pkg::reg_addr_t rd_addr_a,
    output mdio_pkg::reg_data_t rd_data_a,
    input  mdio_pkg::reg_addr_t rd_addr_b,
    output mdio_pkg::reg_data_t rd_data_b
);

    // one entry per phy register
    mdio_pkg::reg_data_t regs [mdio_pkg::NUM_REGS];

    always_ff @(posedge enet_mdc_clk) begin
        if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // port a for the dump writer
    assign rd_data_a = regs[rd_addr_a];

    // port b for external readback
    assign rd_data_b = regs[rd_addr_b];

endmodule

// File: hw/phy_dump_writer.sv
`timescale 1ns/1ps

module phy_dump_writer (
    input  logic                 enet_mdc_clk,
    input  logic                 CPU_RESETn,
    input  logic                 sweep_done,
    output mdio_pkg::reg_addr_t  rf_addr,
    input  mdio_pkg::reg_data_t  rf_data,
    output logic                 dump_req,
    input  logic                 dump_ack,
    output mdio_pkg::reg_addr_t  dump_addr,
    output mdio_pkg::dump_word_t dump_word,
    output logic                 dump_done
);

    typedef enum logic [2:0] {
        DW_IDLE,
        DW_LOAD,
        DW_REQ,
        DW_RELEASE,
        DW_DONE
    } dump_state_t;

    dump_state_t state;

    always_ff @(posedge enet_mdc_clk) begin
        if (!CPU_RESETn) begin
            state     <= DW_IDLE;
            rf_addr   <= '0;
            dump_req  <= 1'b0;
            dump_done <= 1'b0;
        end else begin
            case (state)
                DW_IDLE: begin
                    if (sweep_done) begin
                        state <= DW_LOAD;
                    end
                end
                DW_LOAD: begin
                    // a new word only once the previous ack is gone
                    if (!dump_ack) begin
                        dump_req <= 1'b1;
                        state    <= DW_REQ;
                    end
                end
                DW_REQ: begin
                    if (dump_ack) begin
                        dump_req <= 1'b0;
                        state    <= DW_RELEASE;
                    end
                end
                DW_RELEASE: begin
                    if (!dump_ack) begin
                        if (rf_addr == 5'(mdio_pkg::NUM_REGS - 1)) begin
                            dump_done <= 1'b1;
                            state     <= DW_DONE;
                        end else begin
                            rf_addr <= rf_addr + 5'd1;
                            state   <= DW_LOAD;
                        end
                    end
                end
                default: begin
                    // stays done until reset
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // word register, held for the whole transfer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge enet_mdc_clk) begin
        if (state == DW_LOAD && !dump_ack) begin
            dump_addr        <= rf_addr;
            dump_word.tag    <= mdio_pkg::DUMP_TAG;
            dump_word.pad_hi <= 3'b000;
            dump_word.addr   <= rf_addr;
            dump_word.pad_lo <= 4'h0;
            dump_word.data   <= rf_data;
        end
    end

endmodule

// File: hw/mdio_phy_reader_top.sv
`timescale 1ns/1ps

module mdio_phy_reader_top (
    input  logic                 enet_mdc_clk,
    input  logic                 CPU_RESETn,
    output logic                 mdio_out,
    output logic                 mdio_oe,
    input  logic                 mdio_in,
    output logic                 sweep_done,
    output logic                 dump_req,
    input  logic                 dump_ack,
    output mdio_pkg::reg_addr_t  dump_addr,
    output mdio_pkg::dump_word_t dump_word,
    output logic                 dump_done,
    input  mdio_pkg::reg_addr_t  rb_addr,
    output mdio_pkg::reg_data_t  rb_data
);

    // sequencer to engine handshake
    logic                rd_req;
    logic                rd_ack;
    mdio_pkg::reg_addr_t rd_addr;
    mdio_pkg::reg_data_t rd_data;

    // register file write side
    logic                wr_en;
    mdio_pkg::reg_addr_t wr_addr;
    mdio_pkg::reg_data_t wr_data;

    // dump writer read side
    mdio_pkg::reg_addr_t rf_addr;
    mdio_pkg::reg_data_t rf_data;

    mdio_frame_engine u_engine (
        .enet_mdc_clk (enet_mdc_clk),
        .CPU_RESETn   (CPU_RESETn),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_ack       (rd_ack),
        .rd_data      (rd_data),
        .mdio_out     (mdio_out),
        .mdio_oe      (mdio_oe),
        .mdio_in      (mdio_in)
    );

    phy_reg_sweep u_sweep (
        .enet_mdc_clk (enet_mdc_clk),
        .CPU_RESETn   (CPU_RESETn),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_ack       (rd_ack),
        .rd_data      (rd_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .sweep_done   (sweep_done)
    );

    phy_reg_file u_reg_file (
        .enet_mdc_clk (enet_mdc_clk),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_addr_a    (rf_addr),
        .rd_data_a    (rf_data),
        .rd_addr_b    (rb_addr),
        .rd_data_b    (rb_data)
    );

    phy_dump_writer u_dump (
        .enet_mdc_clk (enet_mdc_clk),
        .CPU_RESETn   (CPU_RESETn),
        .sweep_done   (sweep_done),
        .rf_addr      (rf_addr),
        .rf_data      (rf_data),
        .dump_req     (dump_req),
        .dump_ack     (dump_ack),
        .dump_addr    (dump_addr),
        .dump_word    (dump_word),
        .dump_done    (dump_done)
    );

endmodule

// File: tests/mdio_phy_model.sv
`timescale 1ns/1ps

module mdio_phy_model (
    input  logic enet_mdc_clk,
    input  logic CPU_RESETn,
    input  logic mdio_out,
    input  logic mdio_oe,
    output logic mdio_in
);

    localparam int CMD_END    = mdio_pkg::PREAMBLE_LEN + mdio_pkg::CMD_LEN;
    localparam int DATA_START = CMD_END + mdio_pkg::TA_LEN;
    localparam int FRAME_LEN  = DATA_START + mdio_pkg::DATA_LEN;

    // register contents, written by the testbench
    mdio_pkg::reg_data_t values [mdio_pkg::NUM_REGS];

    int          frame_count;
    int          field_errors;
    bit          active;
    int          cyc;
    logic [13:0] cmd;
    logic [15:0] reply;

    initial begin
        mdio_in      = 1'b1;
        frame_count  = 0;
        field_errors = 0;
        active       = 1'b0;
        cyc          = 0;
        cmd          = '0;
        reply        = '1;
    end

    task automatic field_error(input string what);
        field_errors++;
        $display("FAIL t=%0t frame %0d cycle %0d: %s", $time, frame_count, cyc, what);
    endtask

    always @(posedge enet_mdc_clk) begin
        logic next_in;
        next_in = 1'b1;
        if (!CPU_RESETn) begin
            active      = 1'b0;
            frame_count = 0;
        end else begin
            // first cycle with the line driven is frame cycle 0
            if (!active && mdio_oe) begin
                active = 1'b1;
                cyc    = 0;
            end
            if (active) begin
                if (cyc < mdio_pkg::PREAMBLE_LEN) begin
                    if (!(mdio_oe && mdio_out)) field_error("preamble bit not a driven one");
                end else if (cyc < CMD_END) begin
                    if (!mdio_oe) field_error("command bit not driven");
                    cmd = {cmd[12:0], mdio_out};
                end else if (mdio_oe) begin
                    field_error("line driven during turnaround or data");
                end
                if (cyc == CMD_END - 1) begin
                    if (cmd[13:12] != mdio_pkg::START_BITS) field_error("bad start bits");
                    if (cmd[11:10] != mdio_pkg::OP_READ) field_error("bad opcode");
                    if (cmd[9:5] != mdio_pkg::PHY_ADDR) field_error("bad phy address");
                    if (cmd[4:0] != 5'(frame_count)) field_error("register out of order");
                    // a foreign phy address leaves the line pulled high
                    reply = (cmd[9:5] == mdio_pkg::PHY_ADDR) ? values[cmd[4:0]] : 16'hffff;
                end
                if (cyc >= DATA_START - 1 && cyc < FRAME_LEN - 1) begin
                    next_in = reply[15 - (cyc - (DATA_START - 1))];
                end
                if (cyc == FRAME_LEN - 1) begin
                    active = 1'b0;
                    frame_count++;
                end
                cyc++;
            end
        end
        #1 mdio_in = next_in;
    end

endmodule

// File: tests/tb_mdio_phy_reader.sv
`timescale 1ns/1ps

module tb_mdio_phy_reader;

    localparam int SWEEP_CYCLES = (64 + 2) * mdio_pkg::NUM_REGS;
    localparam int LIMIT = 2 * (2 * SWEEP_CYCLES + mdio_pkg::POST_RESET_WAIT
                                + mdio_pkg::NUM_REGS * 12);
    localparam int NUM_ACKS = 2 * mdio_pkg::NUM_REGS;

    logic                 enet_mdc_clk;
    logic                 CPU_RESETn;
    logic                 mdio_out;
    logic                 mdio_oe;
    logic                 mdio_in;
    logic                 sweep_done;
    logic                 dump_req;
    logic                 dump_ack;
    mdio_pkg::reg_addr_t  dump_addr;
    mdio_pkg::dump_word_t dump_word;
    logic                 dump_done;
    mdio_pkg::reg_addr_t  rb_addr;
    mdio_pkg::reg_data_t  rb_data;

    // stimulus table, two sets of register values and their dump words
    logic [15:0] vals  [2][mdio_pkg::NUM_REGS];
    logic [31:0] words [2][mdio_pkg::NUM_REGS];

    // ack delay for each dump transfer of both sets
    int          ack_delay [NUM_ACKS];
    int          ack_idx;

    logic [4:0]  seen_addr [$];
    logic [31:0] seen_word [$];

    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    int          err_mark;
    logic        prev_req;
    logic        prev_ack;
    logic [4:0]  prev_addr;
    logic [31:0] prev_word;

    mdio_phy_reader_top dut (.*);

    mdio_phy_model phy (
        .enet_mdc_clk (enet_mdc_clk),
        .CPU_RESETn   (CPU_RESETn),
        .mdio_out     (mdio_out),
        .mdio_oe      (mdio_oe),
        .mdio_in      (mdio_in)
    );

    initial begin
        enet_mdc_clk = 1'b0;
        forever #4 enet_mdc_clk = ~enet_mdc_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_true(input bit ok, input string msg);
        assert (ok) else begin
            errors++;
            $display("FAIL t=%0t %s", $time, msg);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != err_mark) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
    endtask

    task automatic load_model(input int set);
        for (int k = 0; k < mdio_pkg::NUM_REGS; k++) phy.values[k] = vals[set][k];
    endtask

    task automatic check_idle();
        check_true(!mdio_oe && mdio_out, "mdio not idle after reset");
        check_true(!dump_req && !sweep_done && !dump_done, "handshake outputs not low");
    endtask

    task automatic check_sweep(input int set);
        wait_for_sweep();
        check_true(phy.field_errors == 0, "phy model saw frame field errors");
        check_true(phy.frame_count == mdio_pkg::NUM_REGS, "wrong number of frames");
        for (int k = 0; k < mdio_pkg::NUM_REGS; k++) begin
            #1 rb_addr = 5'(k);
            @(posedge enet_mdc_clk);
            check_true(rb_data == vals[set][k], $sformatf("readback %0d = %h", k, rb_data));
        end
    endtask

    task automatic check_dump(input int set);
        while (!dump_done) @(posedge enet_mdc_clk);
        check_true(seen_addr.size() == mdio_pkg::NUM_REGS, "wrong number of dump transfers");
        for (int k = 0; k < seen_addr.size() && k < mdio_pkg::NUM_REGS; k++) begin
            check_true(seen_addr[k] == 5'(k),
                       $sformatf("dump addr %0d at slot %0d", seen_addr[k], k));
            check_true(seen_word[k] == words[set][k],
                       $sformatf("dump word %h at slot %0d", seen_word[k], k));
        end
    endtask

    task automatic wait_for_sweep();
        while (!sweep_done) @(posedge enet_mdc_clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // dump acknowledge, random delay, and port monitor
    //////////////////////////////////////////////////////////////////////

    initial begin
        int delay;
        forever begin
            @(posedge enet_mdc_clk);
            if (CPU_RESETn && dump_req && !dump_ack) begin
                delay = ack_delay[ack_idx % NUM_ACKS];
                ack_idx++;
                repeat (delay) @(posedge enet_mdc_clk);
                seen_addr.push_back(dump_addr);
                seen_word.push_back(dump_word);
                #1 dump_ack = 1'b1;
                do @(posedge enet_mdc_clk); while (dump_req);
                #1 dump_ack = 1'b0;
            end
        end
    end

    always @(posedge enet_mdc_clk) begin
        if (CPU_RESETn && dump_req && prev_req) begin
            check_true(dump_addr == prev_addr && dump_word == prev_word,
                       "dump port changed under req");
        end
        // ack as it stood on the edge that raised req
        if (CPU_RESETn && dump_req && !prev_req) begin
            check_true(!prev_ack, "dump_req rose while dump_ack high");
        end
        prev_req  <= dump_req;
        prev_ack  <= dump_ack;
        prev_addr <= dump_addr;
        prev_word <= dump_word;
    end

    always @(posedge enet_mdc_clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        CPU_RESETn = 1'b0;
        dump_ack   = 1'b0;
        rb_addr    = '0;
        errors     = 0;
        err_mark   = 0;
        tests_run  = 0;
        tests_failed = 0;
        cycles     = 0;
        prev_req   = 1'b0;
        prev_ack   = 1'b0;
        ack_idx    = 0;
        void'($urandom(32'h9eab));
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < mdio_pkg::NUM_REGS; k++) begin
                vals[s][k]  = 16'($urandom);
                words[s][k] = {mdio_pkg::DUMP_TAG, 3'b000, 5'(k), 4'h0, vals[s][k]};
                ack_delay[s * mdio_pkg::NUM_REGS + k] = $urandom % 8;
            end
        end
        load_model(0);

        repeat (3) @(posedge enet_mdc_clk);
        check_idle();
        finish_test("reset values");
        #1 CPU_RESETn = 1'b1;

        check_sweep(0);
        finish_test("frames and readback");
        check_dump(0);
        finish_test("dump transfers under back-pressure");

        // reset partway through a second sweep
        @(posedge enet_mdc_clk);
        #1 CPU_RESETn = 1'b0;
        repeat (3) @(posedge enet_mdc_clk);
        #1 CPU_RESETn = 1'b1;
        while (phy.frame_count < 10) @(posedge enet_mdc_clk);
        #1 CPU_RESETn = 1'b0;
        repeat (3) @(posedge enet_mdc_clk);
        check_idle();
        seen_addr.delete();
        seen_word.delete();
        load_model(1);
        #1 CPU_RESETn = 1'b1;
        check_sweep(1);
        check_dump(1);
        finish_test("reset mid-sweep and new table");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
hw/mdio_pkg.sv
hw/mdio_frame_engine.sv
hw/phy_reg_sweep.sv
hw/phy_reg_file.sv
hw/phy_dump_writer.sv
hw/mdio_phy_reader_top.sv
tests/mdio_phy_model.sv
tests/tb_mdio_phy_reader.sv
